//--- verilog.f
+incdir+verification
src/core_pkg.sv
src/reg_file.sv
src/instr_decoder.sv
src/csr_file.sv
src/core_ctrl.sv
src/core_top.sv
verification/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_program.svh
// program image and the store trace it should produce

logic [31:0] prog [0:prog_words-1];
int          at;
logic [31:0] ecall_pc;
logic [31:0] zero_pc;
logic [31:0] bad_csr_pc;
logic [31:0] bad_csr_word;
logic [31:0] trig1_pc;
logic [31:0] trig2_pc;

logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];
string       exp_test [$];

function automatic logic [31:0] addi_insn(input logic [31:0] rd, input logic [31:0] rs1,
                                          input logic [31:0] imm);
   return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
endfunction

function automatic logic [31:0] add_insn(input logic [31:0] rd, input logic [31:0] rs1,
                                         input logic [31:0] rs2);
   return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] sw_insn(input logic [31:0] rs2, input logic [31:0] rs1,
                                        input logic [31:0] off);
   return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'h23};
endfunction

// src is rs1 or the zimm, f3 picks the csr operation
function automatic logic [31:0] csr_insn(input logic [31:0] f3, input logic [31:0] rd,
                                         input logic [31:0] addr, input logic [31:0] src);
   return {addr[11:0], src[4:0], f3[2:0], rd[4:0], 7'h73};
endfunction

task automatic place(input logic [31:0] w);
   prog[at] = w;
   at++;
endtask

task automatic load_program();
   // unused words are the zero word, which traps as illegal
   for (int i = 0; i < prog_words; i++) begin
      prog[i] = 32'h0;
   end
   at = 0;
   place(addi_insn(1, 0, 100));
   place(addi_insn(2, 0, -7));
   place(add_insn(3, 1, 2));
   place(addi_insn(5, 0, 'h100));
   place(sw_insn(3, 5, 'h300));
   place(addi_insn(4, 3, 'h7ff));
   place(sw_insn(4, 0, 'h404));
   // mscratch read-modify-write
   place(csr_insn(1, 0, 'h340, 1));
   place(csr_insn(1, 8, 'h340, 3));
   place(sw_insn(8, 0, 'h408));
   place(csr_insn(2, 9, 'h340, 5));
   place(sw_insn(9, 0, 'h40c));
   place(csr_insn(2, 10, 'h340, 0));
   place(sw_insn(10, 0, 'h410));
   place(csr_insn(7, 11, 'h340, 'h1d));
   place(sw_insn(11, 0, 'h414));
   place(csr_insn(2, 12, 'h340, 0));
   place(sw_insn(12, 0, 'h418));
   // mtvec to the synchronous handler, then mstatus.mie on
   place(addi_insn(6, 0, 'h440));
   place(add_insn(6, 6, 6));
   place(add_insn(6, 6, 6));
   place(csr_insn(1, 0, 'h305, 6));
   place(csr_insn(6, 0, 'h300, 8));
   ecall_pc = prog_base + 4 * at;
   place(32'h0000_0073);
   place(csr_insn(2, 17, 'h300, 0));
   place(sw_insn(17, 0, 'h430));
   zero_pc = prog_base + 4 * at;
   place(32'h0);
   bad_csr_pc = prog_base + 4 * at;
   bad_csr_word = csr_insn(2, 18, 'h7c0, 0);
   place(bad_csr_word);
   // interrupt handler and mie.meie, mie.mtie
   place(addi_insn(7, 0, 'h460));
   place(add_insn(7, 7, 7));
   place(add_insn(7, 7, 7));
   place(csr_insn(1, 0, 'h305, 7));
   place(addi_insn(19, 0, 'h440));
   place(add_insn(19, 19, 19));
   place(csr_insn(1, 0, 'h304, 19));
   place(addi_insn(20, 0, 1));
   trig1_pc = prog_base + 4 * at;
   place(sw_insn(20, 0, trigger_addr));
   place(addi_insn(20, 0, 3));
   trig2_pc = prog_base + 4 * at;
   place(sw_insn(20, 0, trigger_addr));
   place(addi_insn(23, 0, 'h55));
   place(sw_insn(23, 0, done_addr));

   // synchronous traps: log state, step mepc past the instruction
   at = (handler_a - prog_base) / 4;
   place(csr_insn(2, 13, 'h341, 0));
   place(sw_insn(13, 0, 'h420));
   place(csr_insn(2, 14, 'h342, 0));
   place(sw_insn(14, 0, 'h424));
   place(csr_insn(2, 15, 'h343, 0));
   place(sw_insn(15, 0, 'h428));
   place(csr_insn(2, 16, 'h300, 0));
   place(sw_insn(16, 0, 'h42c));
   place(addi_insn(13, 13, 4));
   place(csr_insn(1, 0, 'h341, 13));
   place(32'h3020_0073);

   // interrupts return to mepc as it stands
   at = (handler_b - prog_base) / 4;
   place(csr_insn(2, 21, 'h342, 0));
   place(sw_insn(21, 0, 'h440));
   place(csr_insn(2, 22, 'h341, 0));
   place(sw_insn(22, 0, 'h444));
   place(32'h3020_0073);
endtask

task automatic expect_store(input string t, input logic [31:0] a, input logic [31:0] d);
   exp_test.push_back(t);
   exp_addr.push_back(a);
   exp_data.push_back(d);
endtask

// mstatus inside the handler: mie cleared, mpie holding the old mie of 1
task automatic handler_stores(input string t, input logic [31:0] epc,
                              input logic [31:0] cause, input logic [31:0] tval);
   expect_store(t, 'h420, epc);
   expect_store(t, 'h424, cause);
   expect_store(t, 'h428, tval);
   expect_store(t, 'h42c, 32'h80);
endtask

task automatic list_stores();
   expect_store("arith", 'h400, 32'd100 + 32'hffff_fff9);
   expect_store("arith", 'h404, 32'd100 - 32'd7 + 32'h7ff);
   expect_store("csr_rmw", 'h408, 32'd100);
   expect_store("csr_rmw", 'h40c, 32'd93);
   expect_store("csr_rmw", 'h410, 32'd93 | 32'h100);
   expect_store("csr_rmw", 'h414, 32'd93 | 32'h100);
   expect_store("csr_rmw", 'h418, (32'd93 | 32'h100) & ~32'h1d);
   handler_stores("ecall", ecall_pc, 32'd11, 32'h0);
   expect_store("mret", 'h430, 32'h88);
   handler_stores("illegal_zero", zero_pc, 32'd2, 32'h0);
   handler_stores("illegal_csr", bad_csr_pc, 32'd2, bad_csr_word);
   expect_store("irq_timer", trigger_addr, 32'd1);
   expect_store("irq_timer", 'h440, 32'h8000_0007);
   expect_store("irq_timer", 'h444, trig1_pc + 4);
   expect_store("irq_ext", trigger_addr, 32'd3);
   expect_store("irq_ext", 'h440, 32'h8000_000b);
   expect_store("irq_ext", 'h444, trig2_pc + 4);
   expect_store("done", done_addr, 32'h55);
endtask

//--- verification/core_tb.sv
`timescale 1ns/10ps

module core_tb;

   localparam logic [31:0] prog_base    = 32'h0000_1000;
   localparam int          prog_words   = 128;
   localparam logic [31:0] handler_a    = 32'h0000_1100;
   localparam logic [31:0] handler_b    = 32'h0000_1180;
   localparam logic [31:0] trigger_addr = 32'h0000_07f0;
   localparam logic [31:0] done_addr    = 32'h0000_07fc;
   localparam int          run_timeout  = 20000;

   logic        clk = 1'b0;
   logic        rstn;
   logic        fetch_req;
   logic [31:0] fetch_addr;
   logic        fetch_valid;
   logic [31:0] fetch_data;
   logic        mem_req;
   logic [31:0] mem_addr;
   logic [31:0] mem_wdata;
   logic        mem_ack;
   logic        ext_intr;
   logic        timer_intr;

   integer      seed = 32'h9dd6_2712;
   int          store_idx = 0;
   logic        done = 1'b0;
   logic [31:0] last_word = 32'h0;
   logic [31:0] ret_expect = 32'h0;

   `include "tb_program.svh"

   core_top core_top_i (.*);

   always #4 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_store(input logic [31:0] a, input logic [31:0] d);
      assert (store_idx < exp_addr.size())
         else abort_run($sformatf("store to %h beyond the end of the expected list", a));
      assert (a == exp_addr[store_idx])
         else abort_run($sformatf("mismatch %s store %0d addr: expected %h actual %h",
                                  exp_test[store_idx], store_idx, exp_addr[store_idx], a));
      assert (d == exp_data[store_idx])
         else abort_run($sformatf("mismatch %s store %0d data: expected %h actual %h",
                                  exp_test[store_idx], store_idx, exp_data[store_idx], d));
      store_idx++;
   endtask

   function automatic logic [31:0] word_at(input logic [31:0] addr);
      int idx;
      idx = int'((addr - prog_base) >> 2);
      if (idx < 0 || idx >= prog_words) begin
         return 32'h0;
      end
      return prog[idx];
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // fetch memory, 1 to 4 cycles of latency
   ////////////////////////////////////////////////////////////////////////////
   initial begin : fetch_model
      logic [31:0] addr;
      int          delay;
      forever begin
         @(posedge clk);
         if (fetch_req) begin
            addr  = fetch_addr;
            delay = 1 + ($random(seed) & 3);
            repeat (delay - 1) @(posedge clk);
            #1;
            fetch_data  = word_at(addr);
            fetch_valid = 1'b1;
            last_word   = word_at(addr);
            // interrupt taken, lines go quiet
            if (addr == handler_b) begin
               ext_intr   = 1'b0;
               timer_intr = 1'b0;
            end
            @(posedge clk);
            #1 fetch_valid = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // store model with interrupt trigger and end marker
   ////////////////////////////////////////////////////////////////////////////
   initial begin : store_model
      logic [31:0] addr;
      logic [31:0] data;
      int          delay;
      forever begin
         @(posedge clk);
         if (mem_req) begin
            addr = mem_addr;
            data = mem_wdata;
            check_store(addr, data);
            if (addr == 32'h420) ret_expect = exp_data[store_idx - 1] + 32'd4;
            if (addr == 32'h444) ret_expect = exp_data[store_idx - 1];
            delay = 1 + ($random(seed) & 3);
            repeat (delay - 1) @(posedge clk);
            #1 mem_ack = 1'b1;
            if (addr == trigger_addr) begin
               timer_intr = data[0];
               ext_intr   = data[1];
            end
            if (addr == done_addr) done = 1'b1;
            @(posedge clk);
            #1 mem_ack = 1'b0;
         end
      end
   end

   // every fetch stays inside the program image
   assert property (@(posedge clk) disable iff (rstn)
      fetch_req |-> (fetch_addr >= prog_base && fetch_addr < prog_base + 4 * prog_words &&
                     fetch_addr[1:0] == 2'b00))
      else abort_run($sformatf("fetch from %h outside the program image", fetch_addr));

   assert property (@(posedge clk) disable iff (rstn)
      (fetch_req && last_word == 32'h0000_0073) |-> fetch_addr == handler_a)
      else abort_run($sformatf("mismatch ecall_vector: expected %h actual %h",
                               handler_a, fetch_addr));

   assert property (@(posedge clk) disable iff (rstn)
      (fetch_req && last_word == 32'h3020_0073) |-> fetch_addr == ret_expect)
      else abort_run($sformatf("mismatch mret_return: expected %h actual %h",
                               ret_expect, fetch_addr));

   initial begin : run
      int cycles;
      rstn        = 1'b1;
      fetch_valid = 1'b0;
      fetch_data  = 32'h0;
      mem_ack     = 1'b0;
      ext_intr    = 1'b0;
      timer_intr  = 1'b0;
      load_program();
      list_stores();
      repeat (16) @(posedge clk);
      #1 rstn = 1'b0;
      cycles = 0;
      while (!done && cycles < run_timeout) begin
         @(posedge clk);
         cycles++;
      end
      if (!done) begin
         abort_run("timeout waiting for the final store of the program");
      end else if (store_idx != exp_addr.size()) begin
         abort_run($sformatf("only %0d of %0d stores seen", store_idx, exp_addr.size()));
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

//--- src/core_top.sv
`timescale 1ns/10ps

module core_top (
   input  logic            clk,
   input  logic            rstn,
   output logic            fetch_req,
   output core_pkg::word_t fetch_addr,
   input  logic            fetch_valid,
   input  core_pkg::word_t fetch_data,
   output logic            mem_req,
   output core_pkg::word_t mem_addr,
   output core_pkg::word_t mem_wdata,
   input  logic            mem_ack,
   input  logic            ext_intr,
   input  logic            timer_intr
);
   import core_pkg::*;

   // decoded instruction
   instr_kind_e kind;
   reg_addr_t   rd;
   reg_addr_t   rs1_addr;
   reg_addr_t   rs2_addr;
   word_t       imm;
   csr_addr_t   csr_addr;
   csr_op_e     csr_op;
   logic        csr_use_imm;
   logic        csr_write;
   word_t       instr_word;

   // address of the instruction in flight, kept for debug probing
   word_t       pc_of_instr;

   word_t       rs1_data;
   word_t       rs2_data;
   logic        reg_we;
   reg_addr_t   reg_waddr;
   word_t       reg_wdata;

   // csr and trap traffic
   logic        csr_en;
   word_t       csr_rdata;
   logic        csr_valid;
   logic        trap_take;
   word_t       trap_cause;
   word_t       trap_tval;
   word_t       trap_epc;
   logic        mret_take;
   word_t       mtvec_base;
   word_t       mepc_value;
   logic        irq_pending;
   word_t       irq_cause;

   core_ctrl     core_ctrl_i     (.*);
   instr_decoder instr_decoder_i (.*);
   reg_file      reg_file_i      (.*);
   csr_file      csr_file_i      (.*);

endmodule

//--- src/core_ctrl.sv
`timescale 1ns/10ps

module core_ctrl (
   input  logic                  clk,
   input  logic                  rstn,
   output logic                  fetch_req,
   output core_pkg::word_t       fetch_addr,
   input  logic                  fetch_valid,
   output logic                  mem_req,
   output core_pkg::word_t       mem_addr,
   output core_pkg::word_t       mem_wdata,
   input  logic                  mem_ack,
   input  core_pkg::instr_kind_e kind,
   input  core_pkg::reg_addr_t   rd,
   input  core_pkg::word_t       imm,
   input  core_pkg::word_t       instr_word,
   output core_pkg::word_t       pc_of_instr,
   input  core_pkg::word_t       rs1_data,
   input  core_pkg::word_t       rs2_data,
   output logic                  reg_we,
   output core_pkg::reg_addr_t   reg_waddr,
   output core_pkg::word_t       reg_wdata,
   output logic                  csr_en,
   input  core_pkg::word_t       csr_rdata,
   input  logic                  csr_valid,
   output logic                  trap_take,
   output core_pkg::word_t       trap_cause,
   output core_pkg::word_t       trap_tval,
   output core_pkg::word_t       trap_epc,
   output logic                  mret_take,
   input  core_pkg::word_t       mtvec_base,
   input  core_pkg::word_t       mepc_value,
   input  logic                  irq_pending,
   input  core_pkg::word_t       irq_cause
);
   import core_pkg::*;

   ctrl_state_e state;
   word_t       pc;
   word_t       alu_b;
   word_t       alu_sum;
   word_t       exc_cause;
   word_t       exc_tval;
   word_t       irq_cause_q;
   logic        irq_hit;
   logic        mret_pend;

   // one adder serves add, addi and the store address
   assign alu_b   = (kind == alu_reg) ? rs2_data : imm;
   assign alu_sum = rs1_data + alu_b;

   assign fetch_addr  = pc;
   assign pc_of_instr = pc;

   // rd is written at the end of the execute cycle itself
   assign reg_we    = (state == s_exec && (kind == alu_imm || kind == alu_reg)) ||
                      (state == s_exec_csr && csr_valid);
   assign reg_waddr = rd;
   assign reg_wdata = (state == s_exec_csr) ? csr_rdata : alu_sum;

   // interrupt cause wins over whatever the instruction raised
   assign trap_take  = (state == s_trap) && !mret_pend;
   assign mret_take  = (state == s_trap) && mret_pend;
   assign trap_cause = irq_hit ? irq_cause_q : exc_cause;
   assign trap_tval  = irq_hit ? '0 : exc_tval;
   assign trap_epc   = pc;

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         state     <= s_init;
         pc        <= reset_pc;
         fetch_req <= 1'b0;
         mem_req   <= 1'b0;
         csr_en    <= 1'b0;
         irq_hit   <= 1'b0;
         mret_pend <= 1'b0;
      end else begin
         fetch_req <= 1'b0;
         mem_req   <= 1'b0;
         csr_en    <= 1'b0;
         case (state)
            s_init: begin
               state     <= s_fetch;
               fetch_req <= 1'b1;
            end
            s_fetch: begin
               if (fetch_valid) begin
                  state <= s_decode;
               end
            end
            s_decode: begin
               case (kind)
                  csr: begin
                     state  <= s_exec_csr;
                     csr_en <= 1'b1;
                  end
                  illegal: state <= s_trap;
                  default: state <= s_exec;
               endcase
            end
            s_exec: begin
               case (kind)
                  store: begin
                     state   <= s_mem;
                     mem_req <= 1'b1;
                  end
                  ecall:   state <= s_trap;
                  mret: begin
                     state     <= s_trap;
                     mret_pend <= 1'b1;
                  end
                  default: state <= s_write;
               endcase
            end
            // unknown csr address ends up as an illegal instruction
            s_exec_csr: state <= csr_valid ? s_write : s_trap;
            s_mem: begin
               if (mem_ack) begin
                  state <= s_write;
               end
            end
            s_write: begin
               pc <= pc + 32'd4;
               if (irq_pending) begin
                  state   <= s_trap;
                  irq_hit <= 1'b1;
               end else begin
                  state     <= s_fetch;
                  fetch_req <= 1'b1;
               end
            end
            s_trap: begin
               pc        <= mret_pend ? mepc_value : mtvec_base;
               irq_hit   <= 1'b0;
               mret_pend <= 1'b0;
               state     <= s_fetch;
               fetch_req <= 1'b1;
            end
            default: state <= s_init;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == s_decode) begin
         exc_cause <= (kind == ecall) ? cause_ecall_m : cause_illegal;
         exc_tval  <= (kind == ecall) ? '0 : instr_word;
      end
      if (state == s_exec && kind == store) begin
         mem_addr  <= alu_sum;
         mem_wdata <= rs2_data;
      end
      // freeze the cause seen at the end of write
      if (state == s_write) begin
         irq_cause_q <= irq_cause;
      end
   end

   // one fetch outstanding at a time
   assert property (@(posedge clk) disable iff (rstn) fetch_req |=> !fetch_req);
   assert property (@(posedge clk) disable iff (rstn) mem_req |-> state == s_mem);

endmodule

//--- src/csr_file.sv
`timescale 1ns/10ps

module csr_file (
   input  logic                clk,
   input  logic                rstn,
   input  logic                csr_en,
   input  core_pkg::csr_addr_t csr_addr,
   input  core_pkg::csr_op_e   csr_op,
   input  logic                csr_use_imm,
   input  logic                csr_write,
   input  core_pkg::word_t     rs1_data,
   input  core_pkg::reg_addr_t rs1_addr,
   output core_pkg::word_t     csr_rdata,
   output logic                csr_valid,
   input  logic                trap_take,
   input  core_pkg::word_t     trap_cause,
   input  core_pkg::word_t     trap_tval,
   input  core_pkg::word_t     trap_epc,
   input  logic                mret_take,
   input  logic                ext_intr,
   input  logic                timer_intr,
   output core_pkg::word_t     mtvec_base,
   output core_pkg::word_t     mepc_value,
   output logic                irq_pending,
   output core_pkg::word_t     irq_cause
);
   import core_pkg::*;

   logic  st_mie;
   logic  st_mpie;
   logic  mie_meie;
   logic  mie_mtie;
   word_t mtvec_q;
   word_t mscratch_q;
   word_t mepc_q;
   word_t mcause_q;
   word_t mtval_q;
   word_t mstatus_w;
   word_t mie_w;
   word_t mip_w;
   word_t operand;
   word_t wdata;
   logic  do_write;
   logic  ext_hit;
   logic  tmr_hit;

   // only the implemented bits exist, the rest read as zero
   always_comb begin
      mstatus_w = '0;
      mstatus_w[mstatus_mie_bit]  = st_mie;
      mstatus_w[mstatus_mpie_bit] = st_mpie;
      mie_w = '0;
      mie_w[mip_meip_bit] = mie_meie;
      mie_w[mip_mtip_bit] = mie_mtie;
      mip_w = '0;
      mip_w[mip_meip_bit] = ext_intr;
      mip_w[mip_mtip_bit] = timer_intr;
   end

   always_comb begin
      csr_valid = 1'b1;
      case (csr_addr)
         csr_mstatus:  csr_rdata = mstatus_w;
         csr_misa:     csr_rdata = misa_value;
         csr_mie:      csr_rdata = mie_w;
         csr_mtvec:    csr_rdata = mtvec_q;
         csr_mscratch: csr_rdata = mscratch_q;
         csr_mepc:     csr_rdata = mepc_q;
         csr_mcause:   csr_rdata = mcause_q;
         csr_mtval:    csr_rdata = mtval_q;
         csr_mip:      csr_rdata = mip_w;
         csr_mhartid:  csr_rdata = '0;
         default: begin
            csr_rdata = '0;
            csr_valid = 1'b0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // read-modify-write
   ////////////////////////////////////////////////////////////////////////////
   assign operand = csr_use_imm ? {27'b0, rs1_addr} : rs1_data;

   always_comb begin
      case (csr_op)
         csr_rw:  wdata = operand;
         csr_rs:  wdata = csr_rdata | operand;
         csr_rc:  wdata = csr_rdata & ~operand;
         default: wdata = csr_rdata;
      endcase
   end

   assign do_write = csr_en && csr_valid && csr_write;

   // misa, mip and mhartid ignore writes
   always_ff @(posedge clk) begin
      if (rstn) begin
         st_mie   <= 1'b0;
         st_mpie  <= 1'b0;
         mie_meie <= 1'b0;
         mie_mtie <= 1'b0;
         mtvec_q  <= '0;
         mcause_q <= '0;
      end else if (trap_take) begin
         st_mpie  <= st_mie;
         st_mie   <= 1'b0;
         mcause_q <= trap_cause;
      end else if (mret_take) begin
         st_mie  <= st_mpie;
         st_mpie <= 1'b1;
      end else if (do_write) begin
         case (csr_addr)
            csr_mstatus: begin
               st_mie  <= wdata[mstatus_mie_bit];
               st_mpie <= wdata[mstatus_mpie_bit];
            end
            csr_mie: begin
               mie_meie <= wdata[mip_meip_bit];
               mie_mtie <= wdata[mip_mtip_bit];
            end
            // direct mode only
            csr_mtvec:  mtvec_q  <= {wdata[31:2], 2'b00};
            csr_mcause: mcause_q <= wdata;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (trap_take) begin
         mepc_q  <= trap_epc;
         mtval_q <= trap_tval;
      end else if (do_write) begin
         case (csr_addr)
            csr_mscratch: mscratch_q <= wdata;
            csr_mepc:     mepc_q     <= {wdata[31:2], 2'b00};
            csr_mtval:    mtval_q    <= wdata;
            default: ;
         endcase
      end
   end

   // external before timer
   assign ext_hit     = mip_w[mip_meip_bit] && mie_meie;
   assign tmr_hit     = mip_w[mip_mtip_bit] && mie_mtie;
   assign irq_pending = st_mie && (ext_hit || tmr_hit);
   assign irq_cause   = ext_hit ? cause_int_ext : cause_int_timer;

   assign mtvec_base = mtvec_q;
   assign mepc_value = mepc_q;

   // controller issues trap entry and mret from different instructions
   assert property (@(posedge clk) disable iff (rstn) !(trap_take && mret_take));

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  fetch_valid,
   input  core_pkg::word_t       fetch_data,
   output core_pkg::instr_kind_e kind,
   output core_pkg::reg_addr_t   rd,
   output core_pkg::reg_addr_t   rs1_addr,
   output core_pkg::reg_addr_t   rs2_addr,
   output core_pkg::word_t       imm,
   output core_pkg::csr_addr_t   csr_addr,
   output core_pkg::csr_op_e     csr_op,
   output logic                  csr_use_imm,
   output logic                  csr_write,
   output core_pkg::word_t       instr_word
);
   import core_pkg::*;

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   instr_kind_e kind_d;
   csr_op_e     op_d;

   assign opcode = fetch_data[6:0];
   assign funct3 = fetch_data[14:12];
   assign funct7 = fetch_data[31:25];

   // anything not matched here, the zero word included, stays illegal
   always_comb begin
      kind_d = illegal;
      op_d   = csr_none;
      case (opcode)
         opc_op_imm: if (funct3 == 3'b000) kind_d = alu_imm;
         opc_op:     if (funct3 == 3'b000 && funct7 == 7'b0) kind_d = alu_reg;
         opc_store:  if (funct3 == 3'b010) kind_d = store;
         opc_system: begin
            if (funct3 == 3'b000) begin
               if (fetch_data == instr_ecall) begin
                  kind_d = ecall;
               end else if (fetch_data == instr_mret) begin
                  kind_d = mret;
               end
            end else if (funct3[1:0] != 2'b00) begin
               kind_d = csr;
               op_d   = csr_op_e'(funct3[1:0]);
            end
         end
         default: kind_d = illegal;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         kind      <= illegal;
         csr_op    <= csr_none;
         csr_write <= 1'b0;
      end else if (fetch_valid) begin
         kind      <= kind_d;
         csr_op    <= op_d;
         // set and clear with rs1 = x0 only read
         csr_write <= (kind_d == csr) && (op_d == csr_rw || fetch_data[19:15] != '0);
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_valid) begin
         instr_word  <= fetch_data;
         rd          <= fetch_data[11:7];
         rs1_addr    <= fetch_data[19:15];
         rs2_addr    <= fetch_data[24:20];
         csr_addr    <= fetch_data[31:20];
         csr_use_imm <= funct3[2];
         if (opcode == opc_store) begin
            imm <= {{20{fetch_data[31]}}, fetch_data[31:25], fetch_data[11:7]};
         end else begin
            imm <= {{20{fetch_data[31]}}, fetch_data[31:20]};
         end
      end
   end

endmodule

//--- src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
   input  logic                clk,
   input  core_pkg::reg_addr_t rs1_addr,
   input  core_pkg::reg_addr_t rs2_addr,
   output core_pkg::word_t     rs1_data,
   output core_pkg::word_t     rs2_data,
   input  logic                reg_we,
   input  core_pkg::reg_addr_t reg_waddr,
   input  core_pkg::word_t     reg_wdata
);
   import core_pkg::*;

   // x0 has no storage
   word_t regs [1:31];

   always_ff @(posedge clk) begin
      if (reg_we && reg_waddr != '0) begin
         regs[reg_waddr] <= reg_wdata;
      end
   end

   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- src/core_pkg.sv
package core_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [11:0] csr_addr_t;

   // instruction classes the core knows how to run
   typedef enum logic [2:0] {
      alu_imm,
      alu_reg,
      store,
      csr,
      ecall,
      mret,
      illegal
   } instr_kind_e;

   // encoding matches funct3[1:0] of the csr instructions
   typedef enum logic [1:0] {
      csr_none = 2'd0,
      csr_rw   = 2'd1,
      csr_rs   = 2'd2,
      csr_rc   = 2'd3
   } csr_op_e;

   typedef enum logic [2:0] {
      s_init,
      s_fetch,
      s_decode,
      s_exec,
      s_exec_csr,
      s_mem,
      s_write,
      s_trap
   } ctrl_state_e;

   localparam word_t reset_pc = 32'h0000_1000;

   // major opcodes
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_system = 7'b1110011;

   // system words with no operands
   localparam word_t instr_ecall = 32'h0000_0073;
   localparam word_t instr_mret  = 32'h3020_0073;

   ////////////////////////////////////////////////////////////////////////////
   // machine csrs
   ////////////////////////////////////////////////////////////////////////////
   localparam csr_addr_t csr_mstatus  = 12'h300;
   localparam csr_addr_t csr_misa     = 12'h301;
   localparam csr_addr_t csr_mie      = 12'h304;
   localparam csr_addr_t csr_mtvec    = 12'h305;
   localparam csr_addr_t csr_mscratch = 12'h340;
   localparam csr_addr_t csr_mepc     = 12'h341;
   localparam csr_addr_t csr_mcause   = 12'h342;
   localparam csr_addr_t csr_mtval    = 12'h343;
   localparam csr_addr_t csr_mip      = 12'h344;
   localparam csr_addr_t csr_mhartid  = 12'hf14;

   localparam word_t cause_illegal   = 32'd2;
   localparam word_t cause_ecall_m   = 32'd11;
   localparam word_t cause_int_timer = 32'h8000_0007;
   localparam word_t cause_int_ext   = 32'h8000_000b;

   localparam logic [4:0] mstatus_mie_bit  = 5'd3;
   localparam logic [4:0] mstatus_mpie_bit = 5'd7;
   localparam logic [4:0] mip_mtip_bit     = 5'd7;
   localparam logic [4:0] mip_meip_bit     = 5'd11;

   // mxl = 1 (32 bit), extension i only
   localparam word_t misa_value = 32'h4000_0100;

endpackage
